/* dv/tb_zynq_top.sv */
module tb_zynq_top;
   import zynq_shell_pkg::*;

   // the six tests need roughly 350 cycles together
   localparam int timeout_cycles_lp = 3000;

   logic                          aclk_i = 1'b0;
   logic                          arst_n_i;
   logic                          csr_wr_i;
   logic                          csr_rd_i;
   logic [csr_addr_width_lp-1:0]  csr_addr_i;
   logic [data_width_lp-1:0]      csr_wdata_i;
   logic [data_width_lp-1:0]      csr_rdata_o;
   logic                          csr_rvalid_o;
   logic [host_addr_width_lp-1:0] host_addr_i;
   logic [data_width_lp-1:0]      host_addr_o;
   logic                          dram_wr_v_i;
   logic                          dram_rd_v_i;
   logic [data_width_lp-1:0]      dram_awaddr_i;
   logic [data_width_lp-1:0]      dram_araddr_i;
   logic [data_width_lp-1:0]      dram_awaddr_o;
   logic [data_width_lp-1:0]      dram_araddr_o;
   logic                          dram_high_o;
   logic                          dev_reset_o;

   int                            seed = 32'hd9e0fc35;
   int                            err_cnt = 0;
   int                            cycles = 0;
   int                            rd_exp;
   int                            wr_exp;
   logic [prof_regions_lp-1:0]    prof_exp;
   logic [data_width_lp-1:0]      base_val;

   zynq_top DUT (.*);

   always #2 aclk_i = ~aclk_i;

   always @(posedge aclk_i) begin
      cycles <= cycles + 1;
      if (cycles >= timeout_cycles_lp) begin
         $display("timeout: the tests did not finish within %0d cycles", cycles);
         $display("FAIL: see errors above");
         $finish;
      end
   end

   task automatic check_eq(input string name, input logic [63:0] got,
                           input logic [63:0] exp);
      if (got !== exp) begin
         $display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
         err_cnt++;
      end
   endtask

   task automatic end_test(input string name, input int e0);
      $display("test %s: %0d errors", name, err_cnt - e0);
   endtask

   task automatic csr_write(input int addr, input logic [data_width_lp-1:0] data);
      @(posedge aclk_i);
      csr_wr_i    <= 1'b1;
      csr_addr_i  <= csr_addr_width_lp'(addr);
      csr_wdata_i <= data;
      @(posedge aclk_i);
      csr_wr_i    <= 1'b0;
   endtask

   task automatic csr_read(input int addr, output logic [data_width_lp-1:0] data);
      @(posedge aclk_i);
      csr_rd_i   <= 1'b1;
      csr_addr_i <= csr_addr_width_lp'(addr);
      @(posedge aclk_i);
      csr_rd_i   <= 1'b0;
      @(negedge aclk_i);
      if (!csr_rvalid_o) begin
         $display("read data valid missing for word %0d", addr);
         err_cnt++;
      end
      data = csr_rdata_o;
   endtask

   // one cycle of DRAM requests while the device runs, checked and recorded
   task automatic dram_strobe(input logic rd, input logic wr,
                              input logic [31:0] ar, input logic [31:0] aw);
      logic [31:0] ar_off;
      logic [31:0] aw_off;
      logic [31:0] ar_exp;
      logic [31:0] aw_exp;
      logic        high_exp;
      ar_off   = ar ^ dram_base_lp;
      aw_off   = aw ^ dram_base_lp;
      ar_exp   = ar_off + base_val;
      aw_exp   = aw_off + base_val;
      high_exp = (rd && ar_off >= mem_limit_lp) || (wr && aw_off >= mem_limit_lp);
      @(posedge aclk_i);
      dram_rd_v_i   <= rd;
      dram_wr_v_i   <= wr;
      dram_araddr_i <= ar;
      dram_awaddr_i <= aw;
      @(negedge aclk_i);
      check_eq("dram_araddr_o", dram_araddr_o, ar_exp);
      check_eq("dram_awaddr_o", dram_awaddr_o, aw_exp);
      check_eq("dram_high_o", dram_high_o, high_exp);
      if (rd) begin
         prof_exp[ar[prof_region_msb_lp:prof_region_lsb_lp]] = 1'b1;
         rd_exp++;
      end
      if (wr) begin
         prof_exp[aw[prof_region_msb_lp:prof_region_lsb_lp]] = 1'b1;
         wr_exp++;
      end
   endtask

   task automatic dram_idle();
      @(posedge aclk_i);
      dram_rd_v_i <= 1'b0;
      dram_wr_v_i <= 1'b0;
      @(negedge aclk_i);
      check_eq("dram_high_o", dram_high_o, 0);
   endtask

   task automatic test_reset_values();
      int          e0;
      logic [31:0] d;
      e0 = err_cnt;
      @(negedge aclk_i);
      check_eq("dev_reset_o", dev_reset_o, 1);
      check_eq("csr_rvalid_o", csr_rvalid_o, 0);
      for (int a = 0; a < 14; a++) begin
         csr_read(a, d);
         check_eq($sformatf("csr_rdata_o word %0d", a), d, 0);
      end
      end_test("reset_values", e0);
   endtask

   task automatic test_reg_access();
      int          e0;
      logic [31:0] d;
      logic [31:0] exp;
      logic [31:0] wr_val [4];
      e0 = err_cnt;
      for (int a = 0; a < 4; a++) begin
         wr_val[a] = $random(seed);
         // the device stays in reset, so the counter words must stay zero
         if (a == 0) begin
            wr_val[a][0] = 1'b0;
         end
         csr_write(a, wr_val[a]);
      end
      for (int a = 4; a < 14; a++) begin
         csr_write(a, $random(seed));
      end
      for (int a = 0; a < 14; a++) begin
         csr_read(a, d);
         exp = (a == 2) ? wr_val[2] : (a < 4) ? {31'b0, wr_val[a][0]} : 32'b0;
         check_eq($sformatf("csr_rdata_o word %0d", a), d, exp);
      end
      end_test("reg_access", e0);
   endtask

   task automatic test_host_window();
      int          e0;
      logic [29:0] h;
      e0 = err_cnt;
      for (int i = 0; i < 16; i++) begin
         h     = 30'($random(seed));
         h[29] = i[0];
         @(posedge aclk_i);
         host_addr_i <= h;
         @(negedge aclk_i);
         // window bit 29 selects device local space at 0, device DRAM at 8000_0000
         check_eq("host_addr_o", host_addr_o,
                  h[29] ? {4'h0, h[27:0]} : {4'h8, h[27:0]});
      end
      end_test("host_window", e0);
   endtask

   task automatic test_release();
      int          e0;
      logic [31:0] ar;
      logic [31:0] aw;
      e0 = err_cnt;
      csr_write(csr_alloc_lp, 0);
      csr_write(csr_ctrl_lp, 1);
      repeat (3) @(posedge aclk_i);
      @(negedge aclk_i);
      check_eq("dev_reset_o", dev_reset_o, 1);
      base_val = $random(seed);
      csr_write(csr_base_lp, base_val);
      csr_write(csr_alloc_lp, 1);
      // the FSM sees the flag one edge after the write edge
      repeat (2) @(posedge aclk_i);
      @(negedge aclk_i);
      check_eq("dev_reset_o", dev_reset_o, 0);
      for (int i = 0; i < 16; i++) begin
         ar = $random(seed);
         aw = $random(seed);
         // every other pair stays below the limit
         if (i[1]) begin
            ar = dram_base_lp | (ar & 32'h0fff_ffff);
            aw = dram_base_lp | (aw & 32'h0fff_ffff);
         end
         dram_strobe(~i[0], i[0], ar, aw);
      end
      dram_idle();
      end_test("release", e0);
   endtask

   task automatic test_profiler();
      int          e0;
      logic [31:0] d;
      logic [31:0] c0;
      logic [31:0] exp;
      logic [31:0] addrs [7];
      e0 = err_cnt;
      csr_write(csr_cnt_en_lp, 1);
      // regions 0, 1, 31, 32, 64 and 127 cover every profiler word
      addrs = '{32'h8000_0000, 32'h8080_0000, 32'h8ff0_0000, 32'h9000_0000,
                32'ha000_0000, 32'hbf80_0000, 32'h8000_1000};
      for (int i = 0; i < 7; i++) begin
         dram_strobe(i != 6, i[0] == 1'b0, addrs[i], addrs[6-i]);
      end
      dram_idle();
      for (int k = 0; k < 4; k++) begin
         csr_read(csr_prof0_lp + k, d);
         check_eq($sformatf("csr_rdata_o word %0d", 4 + k), d, prof_exp[32*k +: 32]);
      end
      for (int a = 10; a < 14; a++) begin
         csr_read(a, d);
         exp = (a == 10) ? rd_exp : (a == 12) ? wr_exp : 0;
         check_eq($sformatf("csr_rdata_o word %0d", a), d, exp);
      end
      csr_read(csr_cnt0_lp, d);
      check_eq("cycle counter nonzero", d != 0, 1);
      csr_write(csr_cnt_en_lp, 0);
      csr_read(csr_cnt0_lp, c0);
      csr_read(csr_cnt0_lp, d);
      check_eq("csr_rdata_o word 8", d, c0);
      end_test("profiler", e0);
   endtask

   task automatic test_hold();
      int          e0;
      logic [31:0] d;
      logic [31:0] exp;
      e0 = err_cnt;
      csr_write(csr_ctrl_lp, 0);
      repeat (2) @(posedge aclk_i);
      @(negedge aclk_i);
      check_eq("dev_reset_o", dev_reset_o, 1);
      for (int a = 0; a < 14; a++) begin
         csr_read(a, d);
         exp = (a == 1) ? 32'd1 : (a == 2) ? base_val : 32'd0;
         check_eq($sformatf("csr_rdata_o word %0d", a), d, exp);
      end
      end_test("hold", e0);
   endtask

   initial begin
      arst_n_i      = 1'b0;
      csr_wr_i      = 1'b0;
      csr_rd_i      = 1'b0;
      csr_addr_i    = '0;
      csr_wdata_i   = '0;
      host_addr_i   = '0;
      dram_wr_v_i   = 1'b0;
      dram_rd_v_i   = 1'b0;
      dram_awaddr_i = '0;
      dram_araddr_i = '0;
      prof_exp      = '0;
      rd_exp        = 0;
      wr_exp        = 0;
      base_val      = '0;
      repeat (4) @(posedge aclk_i);
      arst_n_i <= 1'b1;
      test_reset_values();
      test_reg_access();
      test_host_window();
      test_release();
      test_profiler();
      test_hold();
      $display("tests run 6, errors %0d, assertion failures %0d",
               err_cnt, DUT.u_assert.fail_cnt);
      if (err_cnt == 0 && DUT.u_assert.fail_cnt == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

/* dv/zynq_top_assert.sv */
module zynq_top_assert (
   input logic                       aclk_i,
   input logic                       arst_n_i,
   input logic                       csr_rd_i,
   input logic                       rvalid_i,
   input logic                       dram_rd_v_i,
   input logic                       dram_wr_v_i,
   input logic                       dram_high_i,
   input logic                       dev_reset_i,
   input zynq_shell_pkg::dev_state_e state_i
   );
   import zynq_shell_pkg::*;

   // number of assertion failures so far
   int fail_cnt = 0;

   // read data is valid for exactly the cycle after a read strobe
   rvalid_follows_rd: assert property (@(posedge aclk_i) disable iff (!arst_n_i)
      rvalid_i == $past(csr_rd_i))
      else begin
         $error("csr_rvalid_o does not follow csr_rd_i by one edge");
         fail_cnt++;
      end

   high_needs_strobe: assert property (@(posedge aclk_i) disable iff (!arst_n_i)
      dram_high_i |-> (dram_rd_v_i || dram_wr_v_i))
      else begin
         $error("dram_high_o is high without a DRAM strobe");
         fail_cnt++;
      end

   reset_matches_hold: assert property (@(posedge aclk_i)
      dev_reset_i == (state_i == e_hold))
      else begin
         $error("dev_reset_o disagrees with the FSM state");
         fail_cnt++;
      end

endmodule

bind zynq_top zynq_top_assert u_assert (
   .aclk_i      (aclk_i),
   .arst_n_i    (arst_n_i),
   .csr_rd_i    (csr_rd_i),
   .rvalid_i    (csr_rvalid_o),
   .dram_rd_v_i (dram_rd_v_i),
   .dram_wr_v_i (dram_wr_v_i),
   .dram_high_i (dram_high_o),
   .dev_reset_i (dev_reset_o),
   .state_i     (u_fsm.state_r)
);

/* project.f */
verilog/zynq_shell_pkg.sv
verilog/zynq_shell_if.sv
verilog/zynq_csr_regs.sv
verilog/dev_reset_fsm.sv
verilog/perf_counters.sv
verilog/addr_map.sv
verilog/zynq_top.sv
dv/zynq_top_assert.sv
dv/tb_zynq_top.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_zynq_top -f project.f
./obj_dir/Vtb_zynq_top +verilator+error+limit+100 > sim.log 2>&1
cat sim.log

if grep -q "FAIL: see errors above" sim.log; then
   exit 1
fi
exit 0

/* verilog/addr_map.sv */
module addr_map
   #(parameter logic [zynq_shell_pkg::data_width_lp-1:0] mem_limit_p =
        zynq_shell_pkg::mem_limit_lp)
   (
   input  logic                                          aclk_i,
   input  logic                                          arst_n_i,
   input  logic [zynq_shell_pkg::host_addr_width_lp-1:0] host_addr_i,
   input  logic                                          dram_wr_v_i,
   input  logic [zynq_shell_pkg::data_width_lp-1:0]      dram_awaddr_i,
   input  logic                                          dram_rd_v_i,
   input  logic [zynq_shell_pkg::data_width_lp-1:0]      dram_araddr_i,
   output logic [zynq_shell_pkg::data_width_lp-1:0]      host_addr_o,
   output logic [zynq_shell_pkg::data_width_lp-1:0]      dram_awaddr_o,
   output logic [zynq_shell_pkg::data_width_lp-1:0]      dram_araddr_o,
   output logic                                          dram_high_o,
   ctrl_if.map                                           ctrl,
   perf_if.profiler                                      perf
   );
   import zynq_shell_pkg::*;

   localparam int region_width_lp = prof_region_msb_lp - prof_region_lsb_lp + 1;

   logic [data_width_lp-1:0]   aw_off;
   logic [data_width_lp-1:0]   ar_off;
   logic [region_width_lp-1:0] aw_region;
   logic [region_width_lp-1:0] ar_region;
   logic [prof_regions_lp-1:0] prof_hit;
   logic [prof_regions_lp-1:0] prof_r;

   // window bit 29 set maps to device local space, clear maps to device DRAM
   assign host_addr_o = {~host_addr_i[host_addr_width_lp-1], 3'b000, host_addr_i[27:0]};

   // strip the device DRAM base, then move into the region the ARM allocated
   assign aw_off        = dram_awaddr_i ^ dram_base_lp;
   assign ar_off        = dram_araddr_i ^ dram_base_lp;
   assign dram_awaddr_o = aw_off + ctrl.dram_base;
   assign dram_araddr_o = ar_off + ctrl.dram_base;

   assign dram_high_o = (dram_wr_v_i && (aw_off >= mem_limit_p))
                     || (dram_rd_v_i && (ar_off >= mem_limit_p));

   assign aw_region = dram_awaddr_i[prof_region_msb_lp:prof_region_lsb_lp];
   assign ar_region = dram_araddr_i[prof_region_msb_lp:prof_region_lsb_lp];

   always_comb begin
      prof_hit = '0;
      if (dram_wr_v_i) begin
         prof_hit[aw_region] = 1'b1;
      end
      if (dram_rd_v_i) begin
         prof_hit[ar_region] = 1'b1;
      end
   end

   // sticky bitmap of the DRAM regions touched during one run
   always_ff @(posedge aclk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         prof_r <= '0;
      end else if (!ctrl.dev_run) begin
         prof_r <= '0;
      end else begin
         prof_r <= prof_r | prof_hit;
      end
   end

   assign perf.prof_bits = prof_r;

endmodule

/* verilog/dev_reset_fsm.sv */
module dev_reset_fsm (
   input  logic    aclk_i,
   input  logic    arst_n_i,
   output logic    dev_reset_o,
   ctrl_if.fsm     ctrl
   );
   import zynq_shell_pkg::*;

   dev_state_e state_r;
   dev_state_e state_n;

   // the device only leaves reset once the ARM side has set up its DRAM
   always_comb begin
      state_n = state_r;
      case (state_r)
         e_hold: begin
            if (ctrl.ctrl_reset_n && ctrl.dram_alloc) begin
               state_n = e_run;
            end
         end
         e_run: begin
            // dropping the allocated flag alone does not stop a running device
            if (!ctrl.ctrl_reset_n) begin
               state_n = e_hold;
            end
         end
         default: state_n = e_hold;
      endcase
   end

   always_ff @(posedge aclk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_r <= e_hold;
      end else begin
         state_r <= state_n;
      end
   end

   assign ctrl.dev_run = (state_r == e_run);
   assign dev_reset_o  = (state_r == e_hold);

endmodule

/* verilog/perf_counters.sv */
module perf_counters
   #(parameter int counter_width_p = zynq_shell_pkg::counter_width_lp)
   (
   input  logic      aclk_i,
   input  logic      arst_n_i,
   input  logic      dram_rd_v_i,
   input  logic      dram_wr_v_i,
   ctrl_if.counter   ctrl,
   perf_if.counter   perf
   );

   // slot 0 counts cycles, slot 1 DRAM reads, slot 2 DRAM writes
   localparam int num_cnt_lp = 3;

   logic [num_cnt_lp-1:0]                      cnt_inc;
   logic [num_cnt_lp-1:0][counter_width_p-1:0] cnt_r;

   assign cnt_inc = {dram_wr_v_i, dram_rd_v_i, ctrl.cnt_en};

   for (genvar i = 0; i < num_cnt_lp; i++) begin : g_cnt
      always_ff @(posedge aclk_i or negedge arst_n_i) begin
         if (!arst_n_i) begin
            cnt_r[i] <= '0;
         end else if (!ctrl.dev_run) begin
            // a held device starts every run from zero
            cnt_r[i] <= '0;
         end else if (cnt_inc[i]) begin
            cnt_r[i] <= cnt_r[i] + 1'b1;
         end
      end
   end

   assign perf.cyc_cnt = cnt_r[0];
   assign perf.rd_cnt  = cnt_r[1];
   assign perf.wr_cnt  = cnt_r[2];

endmodule

/* verilog/zynq_csr_regs.sv */
module zynq_csr_regs
   #(parameter int counter_width_p = zynq_shell_pkg::counter_width_lp)
   (
   input  logic                                        aclk_i,
   input  logic                                        arst_n_i,
   input  logic                                        csr_wr_i,
   input  logic                                        csr_rd_i,
   input  logic [zynq_shell_pkg::csr_addr_width_lp-1:0] csr_addr_i,
   input  logic [zynq_shell_pkg::data_width_lp-1:0]    csr_wdata_i,
   output logic [zynq_shell_pkg::data_width_lp-1:0]    csr_rdata_o,
   output logic                                        csr_rvalid_o,
   ctrl_if.regs                                        ctrl,
   perf_if.reader                                      perf
   );
   import zynq_shell_pkg::*;

   // three counters, each read back as a low and a high word
   localparam int cnt_words_lp  = 6;
   localparam int prof_words_lp = prof_regions_lp / data_width_lp;

   logic                                          ctrl_reset_n_r;
   logic                                          dram_alloc_r;
   logic [data_width_lp-1:0]                      dram_base_r;
   logic                                          cnt_en_r;
   logic [prof_words_lp-1:0][data_width_lp-1:0]   prof_words;
   logic [cnt_words_lp-1:0][data_width_lp-1:0]    cnt_words;
   logic [csr_addr_width_lp-1:0]                  prof_off;
   logic [csr_addr_width_lp-1:0]                  cnt_off;
   logic [data_width_lp-1:0]                      rd_word;
   logic [data_width_lp-1:0]                      rdata_r;
   logic                                          rvalid_r;

   // a 32-bit counter reads back with a zero high word
   function automatic logic [2*data_width_lp-1:0] widen_cnt(
      input logic [counter_width_p-1:0] cnt
   );
      logic [2*data_width_lp-1:0] wide;
      wide = '0;
      wide[counter_width_p-1:0] = cnt;
      return wide;
   endfunction

   always_ff @(posedge aclk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ctrl_reset_n_r <= 1'b0;
         dram_alloc_r   <= 1'b0;
         dram_base_r    <= '0;
         cnt_en_r       <= 1'b0;
      end else if (csr_wr_i) begin
         case (csr_addr_i)
            csr_ctrl_lp:   ctrl_reset_n_r <= csr_wdata_i[0];
            csr_alloc_lp:  dram_alloc_r   <= csr_wdata_i[0];
            csr_base_lp:   dram_base_r    <= csr_wdata_i;
            csr_cnt_en_lp: cnt_en_r       <= csr_wdata_i[0];
            default: ;
         endcase
      end
   end

   assign ctrl.ctrl_reset_n = ctrl_reset_n_r;
   assign ctrl.dram_alloc   = dram_alloc_r;
   assign ctrl.dram_base    = dram_base_r;
   assign ctrl.cnt_en       = cnt_en_r;

   assign prof_words = perf.prof_bits;
   assign cnt_words  = {widen_cnt(perf.wr_cnt), widen_cnt(perf.rd_cnt),
                        widen_cnt(perf.cyc_cnt)};
   assign prof_off   = csr_addr_i - csr_prof0_lp;
   assign cnt_off    = csr_addr_i - csr_cnt0_lp;

   always_comb begin
      rd_word = '0;
      if (csr_addr_i == csr_ctrl_lp) begin
         rd_word[0] = ctrl_reset_n_r;
      end else if (csr_addr_i == csr_alloc_lp) begin
         rd_word[0] = dram_alloc_r;
      end else if (csr_addr_i == csr_base_lp) begin
         rd_word = dram_base_r;
      end else if (csr_addr_i == csr_cnt_en_lp) begin
         rd_word[0] = cnt_en_r;
      end else if (csr_addr_i < csr_cnt0_lp) begin
         rd_word = prof_words[prof_off[1:0]];
      end else if (cnt_off < cnt_words_lp) begin
         rd_word = cnt_words[cnt_off[2:0]];
      end
   end

   always_ff @(posedge aclk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rvalid_r <= 1'b0;
      end else begin
         rvalid_r <= csr_rd_i;
      end
   end

   always_ff @(posedge aclk_i) begin
      if (csr_rd_i) begin
         rdata_r <= rd_word;
      end
   end

   assign csr_rdata_o  = rdata_r;
   assign csr_rvalid_o = rvalid_r;

endmodule

/* verilog/zynq_shell_if.sv */
// control register values shared by the shell blocks
interface ctrl_if;
   import zynq_shell_pkg::*;

   logic                     ctrl_reset_n;
   logic                     dram_alloc;
   logic [data_width_lp-1:0] dram_base;
   logic                     cnt_en;
   // high while the device is out of reset
   logic                     dev_run;

   modport regs    (output ctrl_reset_n, dram_alloc, dram_base, cnt_en);
   modport fsm     (input ctrl_reset_n, dram_alloc, output dev_run);
   modport counter (input cnt_en, dev_run);
   modport map     (input dram_base, dev_run);
endinterface

// instrumentation values read back through the register port
interface perf_if
   #(parameter int counter_width_p = zynq_shell_pkg::counter_width_lp);
   import zynq_shell_pkg::*;

   logic [counter_width_p-1:0] cyc_cnt;
   logic [counter_width_p-1:0] rd_cnt;
   logic [counter_width_p-1:0] wr_cnt;
   logic [prof_regions_lp-1:0] prof_bits;

   modport counter  (output cyc_cnt, rd_cnt, wr_cnt);
   modport profiler (output prof_bits);
   modport reader   (input cyc_cnt, rd_cnt, wr_cnt, prof_bits);
endinterface

/* verilog/zynq_shell_pkg.sv */
package zynq_shell_pkg;

   // register and address width of the ARM side
   localparam int data_width_lp      = 32;
   localparam int csr_addr_width_lp  = 4;

   // the ARM host window port drops the top two address bits
   localparam int host_addr_width_lp = 30;

   // device DRAM starts here and the ARM region behind it is 256 MB
   localparam logic [data_width_lp-1:0] dram_base_lp = 32'h8000_0000;
   localparam logic [data_width_lp-1:0] mem_limit_lp = 32'h1000_0000;

   // each profiler bit covers one 8 MB slice of the DRAM window
   localparam int prof_regions_lp    = 128;
   localparam int prof_region_msb_lp = 29;
   localparam int prof_region_lsb_lp = 23;

   localparam int counter_width_lp   = 64;

   // word addresses of the register port
   localparam logic [csr_addr_width_lp-1:0] csr_ctrl_lp   = 4'd0;
   localparam logic [csr_addr_width_lp-1:0] csr_alloc_lp  = 4'd1;
   localparam logic [csr_addr_width_lp-1:0] csr_base_lp   = 4'd2;
   localparam logic [csr_addr_width_lp-1:0] csr_cnt_en_lp = 4'd3;
   // profiler words follow at 4 to 7
   localparam logic [csr_addr_width_lp-1:0] csr_prof0_lp  = 4'd4;
   // counters at 8 to 13 as cycle lo/hi, read lo/hi, write lo/hi
   localparam logic [csr_addr_width_lp-1:0] csr_cnt0_lp   = 4'd8;

   // device reset sequencer states
   typedef enum logic [0:0] {
      e_hold = 1'b0,
      e_run  = 1'b1
   } dev_state_e;

endpackage

/* verilog/zynq_top.sv */
module zynq_top
   #(parameter int counter_width_p = zynq_shell_pkg::counter_width_lp,
     parameter logic [zynq_shell_pkg::data_width_lp-1:0] mem_limit_p =
        zynq_shell_pkg::mem_limit_lp)
   (
   input  logic                                          aclk_i,
   input  logic                                          arst_n_i,
   input  logic                                          csr_wr_i,
   input  logic                                          csr_rd_i,
   input  logic [zynq_shell_pkg::csr_addr_width_lp-1:0]  csr_addr_i,
   input  logic [zynq_shell_pkg::data_width_lp-1:0]      csr_wdata_i,
   output logic [zynq_shell_pkg::data_width_lp-1:0]      csr_rdata_o,
   output logic                                          csr_rvalid_o,
   input  logic [zynq_shell_pkg::host_addr_width_lp-1:0] host_addr_i,
   output logic [zynq_shell_pkg::data_width_lp-1:0]      host_addr_o,
   input  logic                                          dram_wr_v_i,
   input  logic [zynq_shell_pkg::data_width_lp-1:0]      dram_awaddr_i,
   input  logic                                          dram_rd_v_i,
   input  logic [zynq_shell_pkg::data_width_lp-1:0]      dram_araddr_i,
   output logic [zynq_shell_pkg::data_width_lp-1:0]      dram_awaddr_o,
   output logic [zynq_shell_pkg::data_width_lp-1:0]      dram_araddr_o,
   output logic                                          dram_high_o,
   output logic                                          dev_reset_o
   );

   ctrl_if ctrl ();
   perf_if #(.counter_width_p(counter_width_p)) perf ();

   zynq_csr_regs #(.counter_width_p(counter_width_p)) u_regs (
      .aclk_i       (aclk_i),
      .arst_n_i     (arst_n_i),
      .csr_wr_i     (csr_wr_i),
      .csr_rd_i     (csr_rd_i),
      .csr_addr_i   (csr_addr_i),
      .csr_wdata_i  (csr_wdata_i),
      .csr_rdata_o  (csr_rdata_o),
      .csr_rvalid_o (csr_rvalid_o),
      .ctrl         (ctrl.regs),
      .perf         (perf.reader)
   );

   dev_reset_fsm u_fsm (
      .aclk_i      (aclk_i),
      .arst_n_i    (arst_n_i),
      .dev_reset_o (dev_reset_o),
      .ctrl        (ctrl.fsm)
   );

   perf_counters #(.counter_width_p(counter_width_p)) u_counters (
      .aclk_i      (aclk_i),
      .arst_n_i    (arst_n_i),
      .dram_rd_v_i (dram_rd_v_i),
      .dram_wr_v_i (dram_wr_v_i),
      .ctrl        (ctrl.counter),
      .perf        (perf.counter)
   );

   addr_map #(.mem_limit_p(mem_limit_p)) u_map (
      .aclk_i        (aclk_i),
      .arst_n_i      (arst_n_i),
      .host_addr_i   (host_addr_i),
      .dram_wr_v_i   (dram_wr_v_i),
      .dram_awaddr_i (dram_awaddr_i),
      .dram_rd_v_i   (dram_rd_v_i),
      .dram_araddr_i (dram_araddr_i),
      .host_addr_o   (host_addr_o),
      .dram_awaddr_o (dram_awaddr_o),
      .dram_araddr_o (dram_araddr_o),
      .dram_high_o   (dram_high_o),
      .ctrl          (ctrl.map),
      .perf          (perf.profiler)
   );

endmodule
